// File: design/slurm16_pkg.sv
/* word types, instruction field layout and decode helpers for the slurm16 back end
   compiled first; shared by every design file and the testbench */
package slurm16_pkg;

	localparam int NUM_REGS = 16;	// r0 always reads zero
	localparam int MEM_WORDS = 256;	// default data memory depth that the top level overrides

	typedef logic [15:0] word_t;		// data word
	typedef logic [15:0] addr_t;		// pc or memory address
	typedef logic [3:0] reg_sel_t;		// register number where 0 means no write
	typedef logic [7:0] io_addr_t;		// i/o port number
	typedef logic [NUM_REGS-1:0] reg_mask_t;	// one bit per register

	typedef enum logic [3:0] {
		CLS_NOP        = 4'd0,
		CLS_ALU_RR     = 4'd1,	// rd = rd op rs
		CLS_ALU_RI     = 4'd2,	// rd = rd op imm4
		CLS_ALU_SINGLE = 4'd3,	// rs = rs op 1
		CLS_BRANCH     = 4'd4,
		CLS_LOAD_STORE = 4'd5,	// address in rs, store data in rd
		CLS_PEEK_POKE  = 4'd6,	// peek port rs, poke rs to port rd
		CLS_INTERRUPT  = 4'd7
	} ins_class_e;

	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		XOR = 4'd4,
		SHL = 4'd5,
		SHR = 4'd6,
		MOV = 4'd7,
		NOT = 4'd8,
		NEG = 4'd9
	} alu_op_e;

	localparam int CLASS_HI = 15;
	localparam int CLASS_LO = 12;
	localparam int OP_HI = 11;
	localparam int OP_LO = 8;
	localparam int FLAG_BIT = 11;	// link / store / poke
	localparam int DEST_HI = 7;
	localparam int DEST_LO = 4;
	localparam int SRC_HI = 3;	// also the 4-bit immediate
	localparam int SRC_LO = 0;

	localparam reg_sel_t LINK_REGISTER = 4'd15;
	localparam reg_sel_t INTERRUPT_LINK_REGISTER = 4'd14;

	function automatic ins_class_e ins_class(input word_t ins);
		return ins_class_e'(ins[CLASS_HI:CLASS_LO]);
	endfunction

	function automatic alu_op_e alu_op(input word_t ins);
		return alu_op_e'(ins[OP_HI:OP_LO]);
	endfunction

	function automatic logic ins_flag(input word_t ins);
		return ins[FLAG_BIT];
	endfunction

	function automatic reg_sel_t reg_dest(input word_t ins);
		return ins[DEST_HI:DEST_LO];
	endfunction

	function automatic reg_sel_t reg_src(input word_t ins);
		return ins[SRC_HI:SRC_LO];
	endfunction

	// destination of an instruction, 0 when it writes nothing
	function automatic reg_sel_t writes_register(input word_t ins);
		reg_sel_t sel;
		sel = '0;
		case (ins_class(ins))
			CLS_ALU_SINGLE: sel = reg_src(ins);
			CLS_ALU_RR, CLS_ALU_RI: sel = reg_dest(ins);
			CLS_BRANCH: begin
				if (ins_flag(ins))
					sel = LINK_REGISTER;	// branch and link
			end
			CLS_LOAD_STORE, CLS_PEEK_POKE: begin
				if (!ins_flag(ins))
					sel = reg_dest(ins);	// load or peek
			end
			CLS_INTERRUPT: sel = INTERRUPT_LINK_REGISTER;
			default: sel = '0;
		endcase
		return sel;
	endfunction

	// registers an instruction reads; r0 never counts
	function automatic reg_mask_t reads_registers(input word_t ins);
		reg_mask_t mask;
		mask = '0;
		case (ins_class(ins))
			CLS_ALU_RR: begin
				mask[reg_dest(ins)] = 1'b1;
				mask[reg_src(ins)] = 1'b1;
			end
			CLS_ALU_RI: mask[reg_dest(ins)] = 1'b1;
			CLS_ALU_SINGLE: mask[reg_src(ins)] = 1'b1;
			CLS_LOAD_STORE, CLS_PEEK_POKE: begin
				mask[reg_src(ins)] = 1'b1;
				if (ins_flag(ins))
					mask[reg_dest(ins)] = 1'b1;	// store or poke also reads rd
			end
			default: mask = '0;
		endcase
		mask[0] = 1'b0;
		return mask;
	endfunction

endpackage

// File: design/slurm16_stage_if.sv
/* one pipeline slot passed between stages
   the stage that registers the slot uses source, the next stage uses sink */
`timescale 1ns/1ps

interface slurm16_stage_if;

	logic               valid;		// high one cycle per instruction
	slurm16_pkg::word_t instruction;
	slurm16_pkg::addr_t pc;			// used by branch link and interrupt
	slurm16_pkg::word_t alu_out;		// alu result or memory / port address
	slurm16_pkg::word_t store_data;		// store or poke data
	slurm16_pkg::word_t load_data;		// memory or port read data

	modport source (
		output valid,
		output instruction,
		output pc,
		output alu_out,
		output store_data,
		output load_data
	);

	modport sink (
		input valid,
		input instruction,
		input pc,
		input alu_out,
		input store_data,
		input load_data
	);

endinterface

// File: design/slurm16_regfile.sv
/* sixteen-word register file, two combinational reads and one write per clock
   a read of the register being written returns the new value */
`timescale 1ns/1ps

module slurm16_regfile (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  slurm16_pkg::reg_sel_t  rd_sel_a,
	input  slurm16_pkg::reg_sel_t  rd_sel_b,
	output slurm16_pkg::word_t     rd_data_a,
	output slurm16_pkg::word_t     rd_data_b,
	input  slurm16_pkg::reg_sel_t  wr_sel,
	input  slurm16_pkg::word_t     wr_data
);

	slurm16_pkg::word_t regs [slurm16_pkg::NUM_REGS];

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < slurm16_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_sel != '0) begin	// writes to r0 dropped
			regs[wr_sel] <= wr_data;
		end
	end

	// bypass covers the instruction still in writeback
	assign rd_data_a = (rd_sel_a == '0) ? '0 :
		(rd_sel_a == wr_sel) ? wr_data : regs[rd_sel_a];
	assign rd_data_b = (rd_sel_b == '0) ? '0 :
		(rd_sel_b == wr_sel) ? wr_data : regs[rd_sel_b];

endmodule

// File: design/slurm16_alu.sv
/* combinational ALU used by issue for all three ALU instruction forms */
`timescale 1ns/1ps

module slurm16_alu (
	input  slurm16_pkg::alu_op_e op,
	input  slurm16_pkg::word_t   a,
	input  slurm16_pkg::word_t   b,
	output slurm16_pkg::word_t   result
);

	always_comb begin
		case (op)
			slurm16_pkg::ADD: result = a + b;
			slurm16_pkg::SUB: result = a - b;
			slurm16_pkg::AND: result = a & b;
			slurm16_pkg::OR:  result = a | b;
			slurm16_pkg::XOR: result = a ^ b;
			slurm16_pkg::SHL: result = a << b[3:0];	// shift by low nibble of b
			slurm16_pkg::SHR: result = a >> b[3:0];	// logical shift
			slurm16_pkg::MOV: result = b;
			slurm16_pkg::NOT: result = ~a;
			slurm16_pkg::NEG: result = -a;		// two's complement
			default:          result = '0;		// unused op codes give zero
		endcase
	end

endmodule

// File: design/slurm16_issue.sv
/* takes instructions over the four-phase req/ack port, holds them off on hazards,
   reads operands and registers the executed slot into ex_slot */
`timescale 1ns/1ps

module slurm16_issue (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   ins_req,
	input  slurm16_pkg::word_t     ins_word,
	input  slurm16_pkg::addr_t     ins_pc,
	output logic                   ins_ack,
	output slurm16_pkg::reg_sel_t  rd_sel_a,
	output slurm16_pkg::reg_sel_t  rd_sel_b,
	input  slurm16_pkg::word_t     rd_data_a,
	input  slurm16_pkg::word_t     rd_data_b,
	slurm16_stage_if.source        ex,
	input  slurm16_pkg::reg_sel_t  mem_busy_sel
);

	typedef enum logic [1:0] {IDLE, ACKED, WAIT_LOW} ack_state_e;

	ack_state_e                state;
	slurm16_pkg::ins_class_e   cls;
	slurm16_pkg::reg_mask_t    reads;
	slurm16_pkg::reg_sel_t     ex_busy_sel;
	slurm16_pkg::word_t        alu_b;
	slurm16_pkg::word_t        alu_result;
	slurm16_pkg::word_t        slot_alu_out;
	slurm16_pkg::word_t        slot_store_data;
	logic                      hazard;
	logic                      take;

	assign cls = slurm16_pkg::ins_class(ins_word);
	assign rd_sel_a = (cls == slurm16_pkg::CLS_ALU_SINGLE) ?
		slurm16_pkg::reg_src(ins_word) : slurm16_pkg::reg_dest(ins_word);
	assign rd_sel_b = slurm16_pkg::reg_src(ins_word);

	// destinations still in flight against what the new instruction reads
	assign ex_busy_sel = ex.valid ? slurm16_pkg::writes_register(ex.instruction) : '0;
	assign reads = slurm16_pkg::reads_registers(ins_word);
	assign hazard = reads[ex_busy_sel] | reads[mem_busy_sel];	// bit 0 always clear
	assign take = (state == IDLE) && ins_req && !hazard;

	always_comb begin
		case (cls)
			slurm16_pkg::CLS_ALU_RI:     alu_b = {12'd0, slurm16_pkg::reg_src(ins_word)};
			slurm16_pkg::CLS_ALU_SINGLE: alu_b = 16'd1;	// inc, dec, shift by one
			default:                     alu_b = rd_data_b;
		endcase
	end

	slurm16_alu i_slurm16_alu (
		.op     (slurm16_pkg::alu_op(ins_word)),
		.a      (rd_data_a),
		.b      (alu_b),
		.result (alu_result)
	);

	always_comb begin
		slot_alu_out = '0;
		slot_store_data = rd_data_a;	// rd for store
		case (cls)
			slurm16_pkg::CLS_ALU_RR, slurm16_pkg::CLS_ALU_RI, slurm16_pkg::CLS_ALU_SINGLE:
				slot_alu_out = alu_result;
			slurm16_pkg::CLS_LOAD_STORE: slot_alu_out = rd_data_b;	// address from rs
			slurm16_pkg::CLS_PEEK_POKE: begin
				if (slurm16_pkg::ins_flag(ins_word)) begin
					slot_alu_out = rd_data_a;	// poke port in rd
					slot_store_data = rd_data_b;	// data from rs
				end else begin
					slot_alu_out = rd_data_b;	// peek port in rs
				end
			end
			default: slot_alu_out = '0;	// branch / interrupt carry only the pc
		endcase
	end

	// ack rises on take, drops one cycle after req is seen low
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (take)
						state <= ACKED;
				end
				ACKED: begin
					if (!ins_req)
						state <= WAIT_LOW;
				end
				WAIT_LOW: state <= IDLE;
				default:  state <= IDLE;
			endcase
		end
	end

	assign ins_ack = (state != IDLE);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			ex.valid <= 1'b0;
		else
			ex.valid <= take;	// one cycle per instruction
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			ex.instruction <= ins_word;
			ex.pc <= ins_pc;
			ex.alu_out <= slot_alu_out;
			ex.store_data <= slot_store_data;
			ex.load_data <= '0;	// filled in by the memory stage
		end
	end

endmodule

// File: design/slurm16_memory_stage.sv
/* pipeline slot 3 with the data memory and i/o port accesses for the instruction in ex_slot
   memory is synchronous; port read data is captured on the same edge */
`timescale 1ns/1ps

module slurm16_memory_stage #(
	parameter int MEM_WORDS = slurm16_pkg::MEM_WORDS
) (
	input  logic                   CLK,
	input  logic                   rst_n,
	slurm16_stage_if.sink          ex,
	slurm16_stage_if.source        mem,
	output slurm16_pkg::reg_sel_t  busy_sel,
	output slurm16_pkg::io_addr_t  io_addr,
	output logic                   io_rd,
	output logic                   io_wr,
	output slurm16_pkg::word_t     io_wdata,
	input  slurm16_pkg::word_t     io_rdata
);

	localparam int ADDR_W = $clog2(MEM_WORDS);

	slurm16_pkg::word_t      data_mem [MEM_WORDS];
	logic [MEM_WORDS-1:0]    written;	// unwritten words read as zero
	logic [ADDR_W-1:0]       mem_addr;
	slurm16_pkg::ins_class_e cls;
	logic                    flag;
	logic                    is_store;

	assign cls = slurm16_pkg::ins_class(ex.instruction);
	assign flag = slurm16_pkg::ins_flag(ex.instruction);
	assign mem_addr = ex.alu_out[ADDR_W-1:0];
	assign is_store = ex.valid && (cls == slurm16_pkg::CLS_LOAD_STORE) && flag;

	// port strobes cover the cycle before the slot is registered
	assign io_addr = ex.alu_out[7:0];
	assign io_wdata = ex.store_data;
	assign io_rd = ex.valid && (cls == slurm16_pkg::CLS_PEEK_POKE) && !flag;
	assign io_wr = ex.valid && (cls == slurm16_pkg::CLS_PEEK_POKE) && flag;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			mem.valid <= 1'b0;
			written <= '0;
		end else begin
			mem.valid <= ex.valid;
			if (is_store)
				written[mem_addr] <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (is_store)
			data_mem[mem_addr] <= ex.store_data;
		mem.instruction <= ex.instruction;
		mem.pc <= ex.pc;
		mem.alu_out <= ex.alu_out;
		mem.store_data <= ex.store_data;
		if (cls == slurm16_pkg::CLS_PEEK_POKE)
			mem.load_data <= io_rdata;	// port read
		else
			mem.load_data <= written[mem_addr] ? data_mem[mem_addr] : '0;	// read before write
	end

	assign busy_sel = mem.valid ? slurm16_pkg::writes_register(mem.instruction) : '0;

endmodule

// File: design/slurm16_writeback.sv
/* pipeline slot 4 that picks the destination register and the value written to it
   select 0 means no write, since r0 always reads back as zero */
`timescale 1ns/1ps

module slurm16_writeback (
	input  logic                   CLK,
	input  logic                   rst_n,
	slurm16_stage_if.sink          mem,
	output slurm16_pkg::reg_sel_t  reg_wr_sel,
	output slurm16_pkg::word_t     reg_out
);

	logic               s4_valid;
	slurm16_pkg::word_t s4_instruction;	// instruction in slot 4
	slurm16_pkg::addr_t s4_pc;
	slurm16_pkg::word_t s4_alu_out;
	slurm16_pkg::word_t s4_load_data;
	slurm16_pkg::reg_sel_t sel;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			s4_valid <= 1'b0;
		else
			s4_valid <= mem.valid;
	end

	always_ff @(posedge CLK) begin
		s4_instruction <= mem.instruction;
		s4_pc <= mem.pc;
		s4_alu_out <= mem.alu_out;
		s4_load_data <= mem.load_data;	// memory or port data
	end

	// register choice shared with the hazard check in issue
	assign sel = s4_valid ? slurm16_pkg::writes_register(s4_instruction) : '0;

	always_comb begin
		reg_out = '0;
		if (sel != '0) begin
			case (slurm16_pkg::ins_class(s4_instruction))
				slurm16_pkg::CLS_ALU_RR, slurm16_pkg::CLS_ALU_RI,
				slurm16_pkg::CLS_ALU_SINGLE:
					reg_out = s4_alu_out;
				slurm16_pkg::CLS_BRANCH, slurm16_pkg::CLS_INTERRUPT:
					reg_out = s4_pc;	// link to r15 or r14
				slurm16_pkg::CLS_LOAD_STORE, slurm16_pkg::CLS_PEEK_POKE:
					reg_out = s4_load_data;	// load or peek
				default: reg_out = '0;
			endcase
		end
	end

	assign reg_wr_sel = sel;

endmodule

// File: design/slurm16_backend.sv
/* top level of the slurm16 back end with issue, memory stage, writeback and register file
   instructions enter over req/ack, results leave on wb_sel / wb_data */
`timescale 1ns/1ps

module slurm16_backend #(
	parameter int MEM_WORDS = slurm16_pkg::MEM_WORDS
) (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   ins_req,
	input  slurm16_pkg::word_t     ins_word,
	input  slurm16_pkg::addr_t     ins_pc,
	output logic                   ins_ack,
	output slurm16_pkg::io_addr_t  io_addr,
	output logic                   io_rd,
	output logic                   io_wr,
	output slurm16_pkg::word_t     io_wdata,
	input  slurm16_pkg::word_t     io_rdata,
	output slurm16_pkg::reg_sel_t  wb_sel,
	output slurm16_pkg::word_t     wb_data
);

	slurm16_pkg::reg_sel_t rd_sel_a;
	slurm16_pkg::reg_sel_t rd_sel_b;
	slurm16_pkg::word_t    rd_data_a;
	slurm16_pkg::word_t    rd_data_b;
	slurm16_pkg::reg_sel_t mem_busy_sel;	// pending destination in slot 3

	slurm16_stage_if ex_slot ();
	slurm16_stage_if mem_slot ();

	slurm16_issue i_slurm16_issue (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.ins_req      (ins_req),
		.ins_word     (ins_word),
		.ins_pc       (ins_pc),
		.ins_ack      (ins_ack),
		.rd_sel_a     (rd_sel_a),
		.rd_sel_b     (rd_sel_b),
		.rd_data_a    (rd_data_a),
		.rd_data_b    (rd_data_b),
		.ex           (ex_slot.source),
		.mem_busy_sel (mem_busy_sel)
	);

	slurm16_memory_stage #(.MEM_WORDS(MEM_WORDS)) i_slurm16_memory_stage (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.ex       (ex_slot.sink),
		.mem      (mem_slot.source),
		.busy_sel (mem_busy_sel),
		.io_addr  (io_addr),
		.io_rd    (io_rd),
		.io_wr    (io_wr),
		.io_wdata (io_wdata),
		.io_rdata (io_rdata)
	);

	slurm16_writeback i_slurm16_writeback (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.mem        (mem_slot.sink),
		.reg_wr_sel (wb_sel),
		.reg_out    (wb_data)
	);

	slurm16_regfile i_slurm16_regfile (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.rd_sel_a  (rd_sel_a),
		.rd_sel_b  (rd_sel_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_sel    (wb_sel),
		.wr_data   (wb_data)
	);

endmodule

// File: verification/slurm16_backend_sva.sv
/* handshake and writeback assertions, bound into the slurm16 back end top level */
`timescale 1ns/1ps

module slurm16_backend_sva (
	input logic                  CLK,
	input logic                  rst_n,
	input logic                  ins_req,
	input logic                  ins_ack,
	input slurm16_pkg::reg_sel_t wb_sel
);

	// ack only rises in answer to a request
	ack_needs_req: assert property (@(posedge CLK) disable iff (!rst_n)
		$rose(ins_ack) |-> $past(ins_req))
		else $error("ins_ack rose while ins_req was low");

	ack_holds: assert property (@(posedge CLK) disable iff (!rst_n)
		(ins_ack && ins_req) |=> ins_ack)
		else $error("ins_ack fell before ins_req was dropped");

	// nothing reaches the register file during reset
	quiet_in_reset: assert property (@(posedge CLK) !rst_n |-> (wb_sel == '0))
		else $error("wb_sel nonzero during reset");

endmodule

bind slurm16_backend slurm16_backend_sva i_slurm16_backend_sva (
	.CLK     (CLK),
	.rst_n   (rst_n),
	.ins_req (ins_req),
	.ins_ack (ins_ack),
	.wb_sel  (wb_sel)
);

// File: verification/slurm16_backend_tb.sv
/* issues directed and random instructions to the slurm16 back end over req/ack
   and checks each writeback, peek and poke against a sequential reference model */
`timescale 1ns/1ps

module slurm16_backend_tb;

	localparam int MEM_WORDS = 64;	// small depth so random addresses alias
	localparam int DIRECTED_INS = 36;
	localparam int RANDOM_INS = 300;
	localparam int TIMEOUT_CYCLES = 40 * (DIRECTED_INS + RANDOM_INS) + 100;
	localparam int RAND_SEED = 73619;
	localparam int DRIVE_DELAY = 1;	// ns after the rising edge
	localparam logic [3:0] FLAG_OP = 4'h8;	// bit 11 set for link, store or poke

	typedef struct packed {
		slurm16_pkg::reg_sel_t sel;
		slurm16_pkg::word_t    data;
	} wb_exp_t;

	logic                  CLK;
	logic                  rst_n;
	logic                  ins_req;
	slurm16_pkg::word_t    ins_word;
	slurm16_pkg::addr_t    ins_pc;
	logic                  ins_ack;
	slurm16_pkg::io_addr_t io_addr;
	logic                  io_rd;
	logic                  io_wr;
	slurm16_pkg::word_t    io_wdata;
	slurm16_pkg::word_t    io_rdata;
	slurm16_pkg::reg_sel_t wb_sel;
	slurm16_pkg::word_t    wb_data;

	slurm16_pkg::word_t model_regs [16];		// reference register file
	slurm16_pkg::word_t model_mem [MEM_WORDS];	// reference data memory
	slurm16_pkg::word_t model_port [256];		// reference copy of poked values
	logic [255:0]       model_port_written;
	slurm16_pkg::word_t port_store [256];		// pokes seen by the port model
	logic [255:0]       port_written = '0;

	wb_exp_t               exp_q [$];		// expected writebacks, in issue order
	string                 name_q [$];
	slurm16_pkg::io_addr_t poke_addr_q [$];
	slurm16_pkg::word_t    poke_data_q [$];
	slurm16_pkg::io_addr_t peek_addr_q [$];

	string              test_name;
	slurm16_pkg::addr_t next_pc;
	int                 issued = 0;
	int                 checks = 0;
	int                 value_errors = 0;
	int                 other_errors = 0;
	int                 cycle_count;
	int                 req_hold = 0;	// extra cycles req stays high after ack
	logic               ack_seen;
	logic [1:0]         check_due;		// ack rise delayed by two cycles

	slurm16_backend #(.MEM_WORDS(MEM_WORDS)) i_slurm16_backend (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.ins_req  (ins_req),
		.ins_word (ins_word),
		.ins_pc   (ins_pc),
		.ins_ack  (ins_ack),
		.io_addr  (io_addr),
		.io_rd    (io_rd),
		.io_wr    (io_wr),
		.io_wdata (io_wdata),
		.io_rdata (io_rdata),
		.wb_sel   (wb_sel),
		.wb_data  (wb_data)
	);

	always #5 CLK = ~CLK;

	// port model answers address * 0x0101 until the port is poked
	assign io_rdata = port_written[io_addr] ? port_store[io_addr] : {8'd0, io_addr} * 16'h0101;

	always @(posedge CLK) begin
		if (io_wr) begin
			port_store[io_addr] <= io_wdata;
			port_written[io_addr] <= 1'b1;
		end
	end

	function automatic slurm16_pkg::word_t alu_model(input logic [3:0] op,
			input slurm16_pkg::word_t a, input slurm16_pkg::word_t b);
		slurm16_pkg::word_t r;
		case (slurm16_pkg::alu_op_e'(op))
			slurm16_pkg::ADD: r = a + b;
			slurm16_pkg::SUB: r = a - b;
			slurm16_pkg::AND: r = a & b;
			slurm16_pkg::OR:  r = a | b;
			slurm16_pkg::XOR: r = a ^ b;
			slurm16_pkg::SHL: r = a << b[3:0];
			slurm16_pkg::SHR: r = a >> b[3:0];
			slurm16_pkg::MOV: r = b;
			slurm16_pkg::NOT: r = ~a;
			slurm16_pkg::NEG: r = 16'd0 - a;
			default:          r = '0;
		endcase
		return r;
	endfunction

	// steps the reference state by one instruction, returns the expected write
	function automatic wb_exp_t predict(input slurm16_pkg::word_t ins, input slurm16_pkg::addr_t pc);
		wb_exp_t                 e;
		slurm16_pkg::ins_class_e cls;
		slurm16_pkg::reg_sel_t   rd;
		slurm16_pkg::reg_sel_t   rs;
		slurm16_pkg::io_addr_t   port;
		logic [3:0]              op;
		logic                    flag;
		int                      mem_index;
		cls = slurm16_pkg::ins_class_e'(ins[15:12]);
		op = ins[11:8];
		flag = ins[11];
		rd = ins[7:4];
		rs = ins[3:0];
		mem_index = int'(model_regs[rs]) % MEM_WORDS;	// address always from rs
		e = '0;
		case (cls)
			slurm16_pkg::CLS_ALU_RR: begin
				e.sel = rd;
				e.data = alu_model(op, model_regs[rd], model_regs[rs]);
			end
			slurm16_pkg::CLS_ALU_RI: begin
				e.sel = rd;
				e.data = alu_model(op, model_regs[rd], {12'd0, rs});
			end
			slurm16_pkg::CLS_ALU_SINGLE: begin
				e.sel = rs;
				e.data = alu_model(op, model_regs[rs], 16'd1);
			end
			slurm16_pkg::CLS_BRANCH: begin
				if (flag) begin
					e.sel = slurm16_pkg::LINK_REGISTER;
					e.data = pc;
				end
			end
			slurm16_pkg::CLS_LOAD_STORE: begin
				if (flag) begin
					model_mem[mem_index] = model_regs[rd];
				end else begin
					e.sel = rd;
					e.data = model_mem[mem_index];
				end
			end
			slurm16_pkg::CLS_PEEK_POKE: begin
				if (flag) begin
					port = model_regs[rd][7:0];	// poke port in rd and data in rs
					model_port[port] = model_regs[rs];
					model_port_written[port] = 1'b1;
					poke_addr_q.push_back(port);
					poke_data_q.push_back(model_regs[rs]);
				end else begin
					port = model_regs[rs][7:0];
					peek_addr_q.push_back(port);
					e.sel = rd;
					e.data = model_port_written[port] ? model_port[port] :
						{8'd0, port} * 16'h0101;
				end
			end
			slurm16_pkg::CLS_INTERRUPT: begin
				e.sel = slurm16_pkg::INTERRUPT_LINK_REGISTER;
				e.data = pc;
			end
			default: e = '0;	// nop writes nothing
		endcase
		if (e.sel == '0)
			e.data = '0;	// r0 never written
		else
			model_regs[e.sel] = e.data;
		return e;
	endfunction

	function automatic slurm16_pkg::word_t encode(input slurm16_pkg::ins_class_e cls,
			input logic [3:0] op, input slurm16_pkg::reg_sel_t rd, input slurm16_pkg::reg_sel_t rs);
		return {cls, op, rd, rs};
	endfunction

	// full four-phase handshake, entered and left just after a rising edge
	task automatic issue_ins(input slurm16_pkg::word_t ins);
		exp_q.push_back(predict(ins, next_pc));
		name_q.push_back(test_name);
		ins_word = ins;
		ins_pc = next_pc;
		ins_req = 1'b1;
		do begin
			@(posedge CLK);
			#DRIVE_DELAY;
		end while (!ins_ack);
		repeat (req_hold) begin
			@(posedge CLK);
			#DRIVE_DELAY;
		end
		ins_req = 1'b0;
		while (ins_ack) begin
			@(posedge CLK);
			#DRIVE_DELAY;
		end
		next_pc = next_pc + 16'd2;
		issued++;
	endtask

	task automatic alu_tests();
		test_name = "alu";
		issue_ins(encode(slurm16_pkg::CLS_ALU_RI, slurm16_pkg::ADD, 4'd1, 4'd5));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RI, slurm16_pkg::ADD, 4'd2, 4'd9));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RR, slurm16_pkg::MOV, 4'd3, 4'd2));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RR, slurm16_pkg::SUB, 4'd3, 4'd1));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RR, slurm16_pkg::AND, 4'd2, 4'd1));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RR, slurm16_pkg::OR, 4'd4, 4'd3));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RR, slurm16_pkg::XOR, 4'd4, 4'd1));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RI, slurm16_pkg::SHL, 4'd4, 4'd3));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RI, slurm16_pkg::SHR, 4'd4, 4'd1));
		issue_ins(encode(slurm16_pkg::CLS_ALU_SINGLE, slurm16_pkg::ADD, 4'd0, 4'd5));
		issue_ins(encode(slurm16_pkg::CLS_ALU_SINGLE, slurm16_pkg::NOT, 4'd0, 4'd5));
		issue_ins(encode(slurm16_pkg::CLS_ALU_SINGLE, slurm16_pkg::NEG, 4'd0, 4'd3));
		issue_ins(encode(slurm16_pkg::CLS_ALU_SINGLE, slurm16_pkg::SHL, 4'd0, 4'd1));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RR, slurm16_pkg::ADD, 4'd0, 4'd1));	// r0 target
		issue_ins(encode(slurm16_pkg::CLS_ALU_RI, slurm16_pkg::ADD, 4'd0, 4'd7));
		issue_ins(encode(slurm16_pkg::CLS_ALU_SINGLE, slurm16_pkg::SUB, 4'd0, 4'd0));
	endtask

	task automatic memory_port_tests();
		test_name = "memory";
		issue_ins(encode(slurm16_pkg::CLS_ALU_RI, slurm16_pkg::ADD, 4'd7, 4'd12));	// address
		issue_ins(encode(slurm16_pkg::CLS_ALU_RR, slurm16_pkg::MOV, 4'd8, 4'd4));
		issue_ins(encode(slurm16_pkg::CLS_LOAD_STORE, FLAG_OP, 4'd8, 4'd7));	// store r8
		issue_ins(encode(slurm16_pkg::CLS_LOAD_STORE, 4'h0, 4'd9, 4'd7));
		issue_ins(encode(slurm16_pkg::CLS_LOAD_STORE, 4'h0, 4'd10, 4'd2));	// never written
		test_name = "port";
		issue_ins(encode(slurm16_pkg::CLS_ALU_RI, slurm16_pkg::ADD, 4'd11, 4'd3));
		issue_ins(encode(slurm16_pkg::CLS_PEEK_POKE, 4'h0, 4'd12, 4'd11));
		issue_ins(encode(slurm16_pkg::CLS_PEEK_POKE, FLAG_OP, 4'd11, 4'd9));	// poke r9
		issue_ins(encode(slurm16_pkg::CLS_PEEK_POKE, 4'h0, 4'd13, 4'd11));	// reads poke back
	endtask

	task automatic flow_tests();
		test_name = "branch";
		issue_ins(encode(slurm16_pkg::CLS_BRANCH, FLAG_OP, 4'd0, 4'd0));
		issue_ins(encode(slurm16_pkg::CLS_BRANCH, 4'h0, 4'd0, 4'd0));
		issue_ins(encode(slurm16_pkg::CLS_INTERRUPT, 4'h0, 4'd0, 4'd0));
		issue_ins(encode(slurm16_pkg::CLS_NOP, 4'h0, 4'd3, 4'd3));
	endtask

	// each one reads what the one before wrote
	task automatic dependency_tests();
		test_name = "dependency";
		issue_ins(encode(slurm16_pkg::CLS_ALU_RI, slurm16_pkg::ADD, 4'd1, 4'd1));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RR, slurm16_pkg::ADD, 4'd1, 4'd1));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RR, slurm16_pkg::ADD, 4'd2, 4'd1));
		issue_ins(encode(slurm16_pkg::CLS_ALU_SINGLE, slurm16_pkg::ADD, 4'd0, 4'd2));
		issue_ins(encode(slurm16_pkg::CLS_LOAD_STORE, FLAG_OP, 4'd2, 4'd1));
		issue_ins(encode(slurm16_pkg::CLS_LOAD_STORE, 4'h0, 4'd3, 4'd1));
		issue_ins(encode(slurm16_pkg::CLS_ALU_RR, slurm16_pkg::XOR, 4'd3, 4'd2));
	endtask

	task automatic random_tests();
		slurm16_pkg::ins_class_e cls;
		slurm16_pkg::reg_sel_t   rd;
		slurm16_pkg::reg_sel_t   rs;
		logic [3:0]              op;
		test_name = "random";
		for (int i = 0; i < RANDOM_INS; i++) begin
			cls = slurm16_pkg::ins_class_e'(4'($urandom_range(7, 0)));
			if (cls >= slurm16_pkg::CLS_ALU_RR && cls <= slurm16_pkg::CLS_ALU_SINGLE)
				op = 4'($urandom_range(9, 0));	// defined alu ops only
			else
				op = 4'($urandom_range(15, 0));	// top bit is the flag
			rd = 4'($urandom_range(15, 0));
			rs = 4'($urandom_range(15, 0));
			req_hold = $urandom_range(2, 0);	// slow requester now and then
			issue_ins(encode(cls, op, rd, rs));
		end
		req_hold = 0;
	endtask

	// writeback shows exactly two cycles after ack rises, and nothing in between
	always @(negedge CLK) begin : compare_wb
		wb_exp_t e;
		string   name;
		if (!rst_n) begin
			ack_seen = 1'b0;
			check_due = 2'b00;
		end else begin
			if (check_due[1]) begin
				e = exp_q.pop_front();
				name = name_q.pop_front();
				checks++;
				assert (wb_sel == e.sel) else begin
					value_errors++;
					$display("ERROR %s: wb_sel expected %0d, actual %0d", name, e.sel, wb_sel);
				end
				if (e.sel != '0) begin
					assert (wb_data == e.data) else begin
						value_errors++;
						$display("ERROR %s: wb_data expected %h, actual %h", name, e.data, wb_data);
					end
				end
			end else begin
				assert (wb_sel == '0) else begin
					other_errors++;
					$display("register %0d was written when no instruction was due", wb_sel);
				end
			end
			check_due = {check_due[0], ins_ack && !ack_seen};
			ack_seen = ins_ack;
		end
	end

	always @(negedge CLK) begin : compare_poke
		slurm16_pkg::io_addr_t exp_addr;
		slurm16_pkg::word_t    exp_data;
		if (rst_n && io_wr) begin
			if (poke_addr_q.size() == 0) begin
				other_errors++;
				$display("io_wr pulsed although no poke was issued");
			end else begin
				exp_addr = poke_addr_q.pop_front();
				exp_data = poke_data_q.pop_front();
				assert (io_addr == exp_addr) else begin
					value_errors++;
					$display("ERROR %s: io_addr expected %h, actual %h", test_name, exp_addr, io_addr);
				end
				assert (io_wdata == exp_data) else begin
					value_errors++;
					$display("ERROR %s: io_wdata expected %h, actual %h", test_name, exp_data,
						io_wdata);
				end
			end
		end
	end

	// one io_rd pulse per peek, on the port the peek names
	always @(negedge CLK) begin : compare_peek
		slurm16_pkg::io_addr_t exp_addr;
		if (rst_n && io_rd) begin
			if (peek_addr_q.size() == 0) begin
				other_errors++;
				$display("io_rd pulsed although no peek was issued");
			end else begin
				exp_addr = peek_addr_q.pop_front();
				assert (io_addr == exp_addr) else begin
					value_errors++;
					$display("ERROR %s: io_addr expected %h, actual %h", test_name, exp_addr, io_addr);
				end
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge CLK);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Something failed");
		$finish;
	end

	initial begin
		void'($urandom(RAND_SEED));
		CLK = 1'b0;
		rst_n = 1'b0;
		ins_req = 1'b0;
		ins_word = '0;
		ins_pc = '0;
		next_pc = 16'h0100;
		test_name = "reset";
		model_port_written = '0;
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = '0;	// unwritten memory reads zero
		repeat (5) @(posedge CLK);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		@(posedge CLK);
		#DRIVE_DELAY;
		alu_tests();
		memory_port_tests();
		flow_tests();
		dependency_tests();
		random_tests();
		while (exp_q.size() != 0)
			@(posedge CLK);
		repeat (4) @(posedge CLK);	// catch late stray writes
		if (poke_addr_q.size() != 0 || peek_addr_q.size() != 0 || checks != issued) begin
			other_errors++;
			$display("%0d pokes and %0d peeks never appeared, %0d of %0d writebacks were checked",
				poke_addr_q.size(), peek_addr_q.size(), checks, issued);
		end
		$display("instructions %0d, checks %0d, value errors %0d, other errors %0d",
			issued, checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: slurm16_backend.f
design/slurm16_pkg.sv
design/slurm16_stage_if.sv
design/slurm16_regfile.sv
design/slurm16_alu.sv
design/slurm16_issue.sv
design/slurm16_memory_stage.sv
design/slurm16_writeback.sv
design/slurm16_backend.sv
verification/slurm16_backend_sva.sv
verification/slurm16_backend_tb.sv

// File: Makefile
# Verilator build and run for the slurm16 back end

VERILATOR ?= verilator
TOP ?= slurm16_backend_tb
FILELIST ?= slurm16_backend.f
OBJ_DIR ?= obj_dir
SIM ?= $(OBJ_DIR)/V$(TOP)
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Everything OK

SOURCES := $(wildcard design/*.sv verification/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
